// ==== build.f ====
rtl/exu_pkg.sv
rtl/id_ex_if.sv
rtl/ex_wb_if.sv
rtl/reg_file.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/csr_file.sv
rtl/wb_stage.sv
rtl/exu_core_top.sv
dv/tb_clk_gen.sv
dv/exu_core_tb.sv

// ==== dv/exu_core_tb.sv ====
// Directed regression for the RV64I pipeline: drives the host port and
// checks every commit against a small register and CSR model.
module exu_core_tb import exu_pkg::*; ();

  logic      clk;
  logic      rst;
  logic      i_inst_req;
  inst_t     i_inst;
  xlen_t     i_pc;
  logic      o_inst_ack;
  logic      o_cmt_req;
  xlen_t     o_cmt_pc;
  reg_addr_t o_cmt_rd;
  logic      o_cmt_we;
  xlen_t     o_cmt_wdata;
  logic      o_cmt_jmp;
  xlen_t     o_cmt_jmpaddr;
  logic      o_cmt_skip;
  logic      i_cmt_ack;

  xlen_t regs_m [NUM_REGS];
  xlen_t mscr_m;
  xlen_t pc_next;
  int    n_sent;
  int    seed = 32'h8213;

  tb_clk_gen tb_clk_gen_i (.clk(clk), .rst(rst));

  exu_core_top exu_core_top_i (
    .clk           (clk),
    .rst           (rst),
    .i_inst_req    (i_inst_req),
    .i_inst        (i_inst),
    .i_pc          (i_pc),
    .o_inst_ack    (o_inst_ack),
    .o_cmt_req     (o_cmt_req),
    .o_cmt_pc      (o_cmt_pc),
    .o_cmt_rd      (o_cmt_rd),
    .o_cmt_we      (o_cmt_we),
    .o_cmt_wdata   (o_cmt_wdata),
    .o_cmt_jmp     (o_cmt_jmp),
    .o_cmt_jmpaddr (o_cmt_jmpaddr),
    .o_cmt_skip    (o_cmt_skip),
    .i_cmt_ack     (i_cmt_ack)
  );

  function automatic xlen_t sx32(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  function automatic xlen_t sx12(input logic [11:0] v);
    return {{52{v[11]}}, v};
  endfunction

  function automatic inst_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
      input logic [2:0] f3, input reg_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t u_type(input logic [19:0] imm, input reg_addr_t rd,
      input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic inst_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
      input reg_addr_t rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH};
  endfunction

  function automatic inst_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL};
  endfunction

  // Branch outcome straight from the RV64I compare rules.
  function automatic logic br_taken(input logic [2:0] f3, input xlen_t x, input xlen_t y);
    case (f3)
      3'b000:  return x == y;
      3'b001:  return x != y;
      3'b100:  return $signed(x) < $signed(y);
      3'b101:  return $signed(x) >= $signed(y);
      3'b110:  return x < y;
      default: return x >= y;
    endcase
  endfunction

  task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
    if (exp !== act) begin
      $display("[FAIL] %s expected %h actual %h", name, exp, act);
      $display("Regression failed");
      $fatal(1, "Value mismatch.");
    end
  endtask

  task automatic send(input inst_t inst);
    @(posedge clk);
    i_inst_req <= 1'b1;
    i_inst     <= inst;
    i_pc       <= pc_next;
    pc_next = pc_next + 64'd4;
    n_sent++;
    do @(negedge clk); while (!o_inst_ack);
    @(posedge clk);
    i_inst_req <= 1'b0;
    do @(negedge clk); while (o_inst_ack);
  endtask

  task automatic expect_commit(input string name, input xlen_t pc, input reg_addr_t rd,
      input logic we, input xlen_t wdata, input logic jmp, input logic has_tgt,
      input xlen_t jmpaddr, input logic skip);
    do @(negedge clk); while (!o_cmt_req);
    check_eq({name, " pc"}, pc, o_cmt_pc);
    check_eq({name, " rd"}, 64'(rd), 64'(o_cmt_rd));
    check_eq({name, " we"}, 64'(we), 64'(o_cmt_we));
    check_eq({name, " jmp"}, 64'(jmp), 64'(o_cmt_jmp));
    check_eq({name, " skip"}, 64'(skip), 64'(o_cmt_skip));
    if (skip) begin
      check_eq({name, " nonzero"}, 64'd1, 64'(o_cmt_wdata != '0));  // Counter value.
    end else if (we) begin
      check_eq({name, " wdata"}, wdata, o_cmt_wdata);
    end
    if (has_tgt) begin
      check_eq({name, " target"}, jmpaddr, o_cmt_jmpaddr);
    end
    @(posedge clk);
    i_cmt_ack <= 1'b1;
    do @(negedge clk); while (o_cmt_req);
    @(posedge clk);
    i_cmt_ack <= 1'b0;
  endtask

  task automatic exec(input string name, input inst_t inst, input xlen_t wdata,
      input logic jmp = 1'b0, input xlen_t jmpaddr = '0, input logic skip = 1'b0);
    xlen_t pc;
    logic  we;
    logic  has_tgt;
    pc      = pc_next;
    we      = (inst[11:7] != 5'd0) && (inst[6:0] != OPC_BRANCH);
    has_tgt = inst[6:0] inside {OPC_BRANCH, OPC_JAL, OPC_JALR};
    send(inst);
    expect_commit(name, pc, inst[11:7], we, wdata, jmp, has_tgt, jmpaddr, skip);
    if (we && !skip) begin
      regs_m[inst[11:7]] = wdata;
    end
  endtask

  // LUI then ADDI, the usual way to build a 32-bit constant.
  task automatic load_reg(input reg_addr_t rd, input logic [31:0] val);
    logic [19:0] hi;
    xlen_t       up;
    hi = val[31:12] + {19'b0, val[11]};
    up = sx32({hi, 12'h000});
    exec("load lui", u_type(hi, rd, OPC_LUI), up);
    exec("load addi", i_type(val[11:0], rd, 3'b000, rd, OPC_OP_IMM), up + sx12(val[11:0]));
  endtask

  task automatic test_reset();
    check_eq("reset cmt_req", 64'd0, 64'(o_cmt_req));
    check_eq("reset inst_ack", 64'd0, 64'(o_inst_ack));
    exec("first addi", i_type(12'd5, 5'd0, 3'b000, 5'd1, OPC_OP_IMM), 64'd5);
  endtask

  task automatic test_alu();
    logic [11:0] imm;
    logic [19:0] u;
    xlen_t       a;
    xlen_t       b;
    xlen_t       si;
    xlen_t       pc0;
    load_reg(5'd2, $random(seed));
    load_reg(5'd3, $random(seed));
    a   = regs_m[2];
    b   = regs_m[3];
    imm = 12'($random(seed));
    u   = 20'($random(seed));
    si  = sx12(imm);
    exec("add", r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd4, OPC_OP), a + b);
    exec("sub", r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd5, OPC_OP), a - b);
    exec("xor", r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd4, OPC_OP), a ^ b);
    exec("or", r_type(7'h00, 5'd3, 5'd2, 3'b110, 5'd4, OPC_OP), a | b);
    exec("and", r_type(7'h00, 5'd3, 5'd2, 3'b111, 5'd4, OPC_OP), a & b);
    exec("slt", r_type(7'h00, 5'd3, 5'd2, 3'b010, 5'd4, OPC_OP), {63'b0, $signed(a) < $signed(b)});
    exec("sltu", r_type(7'h00, 5'd3, 5'd2, 3'b011, 5'd4, OPC_OP), {63'b0, a < b});
    exec("sll", r_type(7'h00, 5'd3, 5'd2, 3'b001, 5'd4, OPC_OP), a << b[5:0]);
    exec("srl", r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd4, OPC_OP), a >> b[5:0]);
    exec("sra", r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd4, OPC_OP), $signed(a) >>> b[5:0]);
    exec("addi", i_type(imm, 5'd2, 3'b000, 5'd6, OPC_OP_IMM), a + si);
    exec("slti", i_type(imm, 5'd2, 3'b010, 5'd6, OPC_OP_IMM), {63'b0, $signed(a) < $signed(si)});
    exec("sltiu", i_type(imm, 5'd2, 3'b011, 5'd6, OPC_OP_IMM), {63'b0, a < si});
    exec("xori", i_type(imm, 5'd2, 3'b100, 5'd6, OPC_OP_IMM), a ^ si);
    exec("slli", i_type({6'b0, imm[5:0]}, 5'd2, 3'b001, 5'd6, OPC_OP_IMM), a << imm[5:0]);
    exec("srli", i_type({6'b0, imm[5:0]}, 5'd2, 3'b101, 5'd6, OPC_OP_IMM), a >> imm[5:0]);
    exec("srai", i_type({6'b010000, imm[5:0]}, 5'd2, 3'b101, 5'd6, OPC_OP_IMM),
         $signed(a) >>> imm[5:0]);
    exec("lui", u_type(u, 5'd7, OPC_LUI), sx32({u, 12'h000}));
    exec("auipc", u_type(u, 5'd7, OPC_AUIPC), pc_next + sx32({u, 12'h000}));
    // The held first commit keeps x9 pending, so the reader of x9 stalls in decode.
    pc0 = pc_next;
    send(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd8, OPC_OP));
    send(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd9, OPC_OP));
    fork
      send(r_type(7'h00, 5'd2, 5'd9, 3'b000, 5'd10, OPC_OP));
    join_none
    expect_commit("stall filler", pc0, 5'd8, 1'b1, a ^ b, 1'b0, 1'b0, '0, 1'b0);
    expect_commit("stall first", pc0 + 64'd4, 5'd9, 1'b1, a + b, 1'b0, 1'b0, '0, 1'b0);
    expect_commit("stall second", pc0 + 64'd8, 5'd10, 1'b1, a + b + a, 1'b0, 1'b0, '0, 1'b0);
    wait fork;
    regs_m[8]  = a ^ b;
    regs_m[9]  = a + b;
    regs_m[10] = a + b + a;
  endtask

  task automatic test_word();
    logic [11:0] imm;
    xlen_t       a;
    xlen_t       b;
    xlen_t       si;
    a   = regs_m[2];
    b   = regs_m[3];
    imm = 12'($random(seed));
    si  = sx12(imm);
    exec("addiw", i_type(imm, 5'd2, 3'b000, 5'd10, OPC_OP_IMM_32), sx32(a[31:0] + si[31:0]));
    exec("addw", r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd10, OPC_OP_32), sx32(a[31:0] + b[31:0]));
    exec("subw", r_type(7'h20, 5'd3, 5'd2, 3'b000, 5'd10, OPC_OP_32), sx32(a[31:0] - b[31:0]));
    exec("sllw", r_type(7'h00, 5'd3, 5'd2, 3'b001, 5'd10, OPC_OP_32), sx32(a[31:0] << b[4:0]));
    exec("srlw", r_type(7'h00, 5'd3, 5'd2, 3'b101, 5'd10, OPC_OP_32), sx32(a[31:0] >> b[4:0]));
    exec("sraw", r_type(7'h20, 5'd3, 5'd2, 3'b101, 5'd10, OPC_OP_32),
         sx32($signed(a[31:0]) >>> b[4:0]));
    exec("slliw", i_type({7'h00, imm[4:0]}, 5'd2, 3'b001, 5'd10, OPC_OP_IMM_32),
         sx32(a[31:0] << imm[4:0]));
    exec("srliw", i_type({7'h00, imm[4:0]}, 5'd2, 3'b101, 5'd10, OPC_OP_IMM_32),
         sx32(a[31:0] >> imm[4:0]));
    exec("sraiw", i_type({7'h20, imm[4:0]}, 5'd2, 3'b101, 5'd10, OPC_OP_IMM_32),
         sx32($signed(a[31:0]) >>> imm[4:0]));
  endtask

  task automatic test_jump();
    logic [2:0]  f3s [6];
    logic [12:0] off;
    logic [20:0] joff;
    logic [11:0] imm;
    reg_addr_t   rs1;
    reg_addr_t   rs2;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    for (int i = 0; i < 6; i++) begin
      for (int k = 0; k < 3; k++) begin
        rs1 = (k == 1) ? 5'd3 : 5'd2;  // Pairs (x2,x3), (x3,x2), (x2,x2).
        rs2 = (k == 0) ? 5'd3 : 5'd2;
        off = 13'($random(seed));
        off[0] = 1'b0;
        exec("branch", b_type(off, rs2, rs1, f3s[i]), '0,
             br_taken(f3s[i], regs_m[rs1], regs_m[rs2]), pc_next + {{51{off[12]}}, off});
      end
    end
    joff = 21'($random(seed));
    joff[0] = 1'b0;
    exec("jal", j_type(joff, 5'd11), pc_next + 64'd4, 1'b1, pc_next + {{43{joff[20]}}, joff});
    imm = 12'($random(seed));
    imm[0] = ~regs_m[2][0];  // Odd sum, so bit 0 must be cleared.
    exec("jalr", i_type(imm, 5'd2, 3'b000, 5'd12, OPC_JALR), pc_next + 64'd4, 1'b1,
         (regs_m[2] + sx12(imm)) & ~64'd1);
  endtask

  task automatic test_csr();
    xlen_t a;
    xlen_t b;
    a = regs_m[2];
    b = regs_m[3];
    exec("csrrw", i_type(CSR_MSCRATCH, 5'd2, 3'b001, 5'd13, OPC_SYSTEM), mscr_m);
    mscr_m = a;
    exec("csrrs", i_type(CSR_MSCRATCH, 5'd3, 3'b010, 5'd14, OPC_SYSTEM), mscr_m);
    mscr_m = mscr_m | b;
    exec("csrrc", i_type(CSR_MSCRATCH, 5'd2, 3'b011, 5'd15, OPC_SYSTEM), mscr_m);
    mscr_m = mscr_m & ~a;
    exec("csrrwi", i_type(CSR_MSCRATCH, 5'h15, 3'b101, 5'd16, OPC_SYSTEM), mscr_m);
    mscr_m = 64'h15;
    exec("csrrsi", i_type(CSR_MSCRATCH, 5'h0a, 3'b110, 5'd16, OPC_SYSTEM), mscr_m);
    mscr_m = mscr_m | 64'h0a;
    exec("csrrci", i_type(CSR_MSCRATCH, 5'h03, 3'b111, 5'd16, OPC_SYSTEM), mscr_m);
    mscr_m = mscr_m & ~64'h03;
    exec("csr read", i_type(CSR_MSCRATCH, 5'd0, 3'b010, 5'd17, OPC_SYSTEM), mscr_m);
    exec("mcycle", i_type(CSR_MCYCLE, 5'd0, 3'b010, 5'd5, OPC_SYSTEM), '0, 1'b0, '0, 1'b1);
  endtask

  task automatic test_backpressure();
    xlen_t a;
    xlen_t b;
    xlen_t pc0;
    a   = regs_m[2];
    b   = regs_m[3];
    pc0 = pc_next;
    send(r_type(7'h00, 5'd3, 5'd2, 3'b000, 5'd18, OPC_OP));
    send(r_type(7'h00, 5'd3, 5'd2, 3'b100, 5'd19, OPC_OP));
    send(i_type(12'h123, 5'd2, 3'b000, 5'd20, OPC_OP_IMM));
    repeat (20) begin
      @(negedge clk);
      check_eq("hold req", 64'd1, 64'(o_cmt_req));
      check_eq("hold pc", pc0, o_cmt_pc);
      check_eq("hold wdata", a + b, o_cmt_wdata);
    end
    expect_commit("bp add", pc0, 5'd18, 1'b1, a + b, 1'b0, 1'b0, '0, 1'b0);
    expect_commit("bp xor", pc0 + 64'd4, 5'd19, 1'b1, a ^ b, 1'b0, 1'b0, '0, 1'b0);
    expect_commit("bp addi", pc0 + 64'd8, 5'd20, 1'b1, a + 64'h123, 1'b0, 1'b0, '0, 1'b0);
  endtask

  initial begin
    i_inst_req = 1'b0;
    i_inst     = '0;
    i_pc       = '0;
    i_cmt_ack  = 1'b0;
    mscr_m     = '0;
    pc_next    = 64'h1000;
    n_sent     = 0;
    for (int i = 0; i < NUM_REGS; i++) begin
      regs_m[i] = '0;
    end
    wait (rst === 1'b0);
    @(negedge clk);
    test_reset();
    test_alu();
    test_word();
    test_jump();
    test_csr();
    test_backpressure();
    $display("Regression passed");
    $finish;
  end

  // Budget of 200 cycles per instruction sent so far.
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles <= 200 * (n_sent + 1)) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the DUT stopped answering after %0d cycles", cycles);
    $display("Regression failed");
    $fatal(1, "Watchdog expired.");
  end

endmodule

// ==== dv/tb_clk_gen.sv ====
// Testbench clock and synchronous reset for the pipeline regression.
module tb_clk_gen (
  output logic clk,
  output logic rst
);

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  initial begin
    rst = 1'b1;
    repeat (4) @(posedge clk);
    rst <= 1'b0;  // Four cycles of reset.
  end

endmodule

// ==== rtl/csr_file.sv ====
// Machine CSRs: mscratch and the free-running mcycle counter.
// Reads are combinational; other addresses read zero and drop writes.
module csr_file import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  csr_addr_t i_csr_addr,
  input  logic      i_csr_wen,
  input  xlen_t     i_csr_wdata,
  output xlen_t     o_csr_rdata
);

  xlen_t mscratch;
  xlen_t mcycle;

  always_ff @(posedge clk) begin
    if (rst) begin
      mscratch <= '0;
      mcycle   <= '0;
    end else begin
      if (i_csr_wen && (i_csr_addr == CSR_MSCRATCH)) begin
        mscratch <= i_csr_wdata;
      end
      if (i_csr_wen && (i_csr_addr == CSR_MCYCLE)) begin
        mcycle <= i_csr_wdata;  // Write replaces this cycle's increment.
      end else begin
        mcycle <= mcycle + 64'd1;
      end
    end
  end

  always_comb begin
    case (i_csr_addr)
      CSR_MSCRATCH: o_csr_rdata = mscratch;
      CSR_MCYCLE:   o_csr_rdata = mcycle;
      default:      o_csr_rdata = '0;
    endcase
  end

endmodule

// ==== rtl/ex_stage.sv ====
// Execute stage: ALU, branch and jump resolution, and CSR read-modify-write.
// The result is computed in the capture cycle and registered toward write-back.
module ex_stage import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  id_ex_if.dst      id_ex,
  ex_wb_if.src      ex_wb,
  output csr_addr_t o_csr_addr,
  output logic      o_csr_wen,
  output xlen_t     o_csr_wdata,
  input  xlen_t     i_csr_rdata
);

  logic  accept;
  logic  fire_q;
  logic  is_csr;
  logic  eq;
  logic  lt_s;
  logic  lt_u;
  logic  jmp;
  xlen_t jmp_addr;
  xlen_t sum;
  xlen_t diff;
  xlen_t alu_res;

  function automatic xlen_t sext_w(input logic [31:0] v);
    return {{32{v[31]}}, v};
  endfunction

  assign sum  = id_ex.op1 + id_ex.op2;
  assign diff = id_ex.op1 - id_ex.op2;
  assign eq   = (id_ex.op1 == id_ex.op2);
  assign lt_s = ($signed(id_ex.op1) < $signed(id_ex.op2));
  assign lt_u = (id_ex.op1 < id_ex.op2);

  assign is_csr = id_ex.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                   OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};

  // Capture only when nothing is still waiting on the write-back link.
  assign accept = id_ex.req && !id_ex.ack && !fire_q && !ex_wb.req && !ex_wb.ack;

  always_comb begin
    case (id_ex.op)
      OP_ADD, OP_ADDI, OP_LUI, OP_AUIPC, OP_JAL: alu_res = sum;
      OP_SUB:             alu_res = diff;
      OP_SLL, OP_SLLI:    alu_res = id_ex.op1 << id_ex.op2[5:0];
      OP_SLT, OP_SLTI:    alu_res = {63'b0, lt_s};
      OP_SLTU, OP_SLTIU:  alu_res = {63'b0, lt_u};
      OP_XOR, OP_XORI:    alu_res = id_ex.op1 ^ id_ex.op2;
      OP_OR, OP_ORI:      alu_res = id_ex.op1 | id_ex.op2;
      OP_AND, OP_ANDI:    alu_res = id_ex.op1 & id_ex.op2;
      OP_SRL, OP_SRLI:    alu_res = id_ex.op1 >> id_ex.op2[5:0];
      OP_SRA, OP_SRAI:    alu_res = $signed(id_ex.op1) >>> id_ex.op2[5:0];
      OP_ADDW, OP_ADDIW:  alu_res = sext_w(sum[31:0]);
      OP_SUBW:            alu_res = sext_w(diff[31:0]);
      OP_SLLW, OP_SLLIW:  alu_res = sext_w(id_ex.op1[31:0] << id_ex.op2[4:0]);
      OP_SRLW, OP_SRLIW:  alu_res = sext_w(id_ex.op1[31:0] >> id_ex.op2[4:0]);
      OP_SRAW, OP_SRAIW:  alu_res = sext_w($signed(id_ex.op1[31:0]) >>> id_ex.op2[4:0]);
      OP_JALR:            alu_res = id_ex.op3;  // pc+4.
      OP_CSRRW, OP_CSRRS, OP_CSRRC,
      OP_CSRRWI, OP_CSRRSI, OP_CSRRCI: alu_res = i_csr_rdata;
      default:            alu_res = '0;
    endcase
  end

  always_comb begin
    jmp      = 1'b0;
    jmp_addr = id_ex.op3;
    case (id_ex.op)
      OP_BEQ:  jmp = eq;
      OP_BNE:  jmp = !eq;
      OP_BLT:  jmp = lt_s;
      OP_BGE:  jmp = !lt_s;
      OP_BLTU: jmp = lt_u;
      OP_BGEU: jmp = !lt_u;
      OP_JAL:  jmp = 1'b1;
      OP_JALR: begin
        jmp      = 1'b1;
        jmp_addr = {sum[63:1], 1'b0};
      end
      default: jmp_addr = '0;
    endcase
  end

  assign o_csr_addr = id_ex.op2[11:0];
  assign o_csr_wen  = accept && is_csr;  // Single pulse with the ack edge.

  always_comb begin
    case (id_ex.op)
      OP_CSRRS, OP_CSRRSI: o_csr_wdata = i_csr_rdata | id_ex.op1;
      OP_CSRRC, OP_CSRRCI: o_csr_wdata = i_csr_rdata & ~id_ex.op1;
      default:             o_csr_wdata = id_ex.op1;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.ack <= 1'b0;
      ex_wb.req <= 1'b0;
      fire_q    <= 1'b0;
    end else begin
      fire_q <= accept;
      if (accept) begin
        id_ex.ack <= 1'b1;
      end else if (id_ex.ack && !id_ex.req) begin
        id_ex.ack <= 1'b0;
      end
      if (fire_q) begin
        ex_wb.req <= 1'b1;  // One cycle after capture.
      end else if (ex_wb.req && ex_wb.ack) begin
        ex_wb.req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      ex_wb.rd      <= id_ex.rd;
      ex_wb.rd_we   <= id_ex.rd_we;
      ex_wb.wdata   <= alu_res;
      ex_wb.jmp     <= jmp;
      ex_wb.jmpaddr <= jmp_addr;
      ex_wb.skip    <= is_csr && (o_csr_addr == CSR_MCYCLE);
      ex_wb.pc      <= id_ex.pc;
    end
  end

endmodule

// ==== rtl/ex_wb_if.sv ====
// Execute to write-back link, four-phase req/ack with the result payload.
interface ex_wb_if import exu_pkg::*; ();

  logic      req;
  logic      ack;
  reg_addr_t rd;
  logic      rd_we;
  xlen_t     wdata;
  logic      jmp;
  xlen_t     jmpaddr;
  logic      skip;  // Result must not be compared, e.g. an mcycle read.
  xlen_t     pc;

  modport src (output req, rd, rd_we, wdata, jmp, jmpaddr, skip, pc, input ack);
  modport dst (input req, rd, rd_we, wdata, jmp, jmpaddr, skip, pc, output ack);

endinterface

// ==== rtl/exu_core_top.sv ====
// Top of the decode, execute and write-back pipeline.
// Instructions enter and commits leave over four-phase req/ack ports.
module exu_core_top import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  input  logic      i_inst_req,
  input  inst_t     i_inst,
  input  xlen_t     i_pc,
  output logic      o_inst_ack,
  output logic      o_cmt_req,
  output xlen_t     o_cmt_pc,
  output reg_addr_t o_cmt_rd,
  output logic      o_cmt_we,
  output xlen_t     o_cmt_wdata,
  output logic      o_cmt_jmp,
  output xlen_t     o_cmt_jmpaddr,
  output logic      o_cmt_skip,
  input  logic      i_cmt_ack
);

  reg_addr_t           rs1_addr;
  reg_addr_t           rs2_addr;
  xlen_t               rs1_data;
  xlen_t               rs2_data;
  logic                mark_en;
  reg_addr_t           mark_addr;
  logic [NUM_REGS-1:0] busy;
  logic                wr_en;
  reg_addr_t           wr_addr;
  xlen_t               wr_data;
  csr_addr_t           csr_addr;
  logic                csr_wen;
  xlen_t               csr_wdata;
  xlen_t               csr_rdata;

  id_ex_if id_ex_i ();
  ex_wb_if ex_wb_i ();

  reg_file reg_file_i (
    .clk         (clk),
    .rst         (rst),
    .i_rs1_addr  (rs1_addr),
    .i_rs2_addr  (rs2_addr),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data),
    .i_mark_en   (mark_en),
    .i_mark_addr (mark_addr),
    .i_wr_en     (wr_en),
    .i_wr_addr   (wr_addr),
    .i_wr_data   (wr_data),
    .o_busy      (busy)
  );

  id_stage id_stage_i (
    .clk         (clk),
    .rst         (rst),
    .i_inst_req  (i_inst_req),
    .i_inst      (i_inst),
    .i_pc        (i_pc),
    .o_inst_ack  (o_inst_ack),
    .o_rs1_addr  (rs1_addr),
    .o_rs2_addr  (rs2_addr),
    .i_rs1_data  (rs1_data),
    .i_rs2_data  (rs2_data),
    .o_mark_en   (mark_en),
    .o_mark_addr (mark_addr),
    .i_busy      (busy),
    .id_ex       (id_ex_i)
  );

  ex_stage ex_stage_i (
    .clk         (clk),
    .rst         (rst),
    .id_ex       (id_ex_i),
    .ex_wb       (ex_wb_i),
    .o_csr_addr  (csr_addr),
    .o_csr_wen   (csr_wen),
    .o_csr_wdata (csr_wdata),
    .i_csr_rdata (csr_rdata)
  );

  csr_file csr_file_i (
    .clk         (clk),
    .rst         (rst),
    .i_csr_addr  (csr_addr),
    .i_csr_wen   (csr_wen),
    .i_csr_wdata (csr_wdata),
    .o_csr_rdata (csr_rdata)
  );

  wb_stage wb_stage_i (
    .clk           (clk),
    .rst           (rst),
    .ex_wb         (ex_wb_i),
    .o_wr_en       (wr_en),
    .o_wr_addr     (wr_addr),
    .o_wr_data     (wr_data),
    .o_cmt_req     (o_cmt_req),
    .o_cmt_pc      (o_cmt_pc),
    .o_cmt_rd      (o_cmt_rd),
    .o_cmt_we      (o_cmt_we),
    .o_cmt_wdata   (o_cmt_wdata),
    .o_cmt_jmp     (o_cmt_jmp),
    .o_cmt_jmpaddr (o_cmt_jmpaddr),
    .o_cmt_skip    (o_cmt_skip),
    .i_cmt_ack     (i_cmt_ack)
  );

endmodule

// ==== rtl/exu_pkg.sv ====
// Types, opcodes and CSR addresses shared by the RV64I execution pipeline.
// Every pipeline module takes these through a wildcard import.
package exu_pkg;

  typedef logic [63:0] xlen_t;
  typedef logic [31:0] inst_t;
  typedef logic [4:0]  reg_addr_t;
  typedef logic [11:0] csr_addr_t;

  localparam int NUM_REGS = 32;

  localparam csr_addr_t CSR_MSCRATCH = 12'h340;
  localparam csr_addr_t CSR_MCYCLE   = 12'hB00;

  // Major opcodes, bits 6:0 of the instruction.
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;

  typedef enum logic [7:0] {
    OP_NOP,
    OP_ADD, OP_SUB, OP_SLL, OP_SLT, OP_SLTU,
    OP_XOR, OP_SRL, OP_SRA, OP_OR, OP_AND,
    OP_ADDI, OP_SLTI, OP_SLTIU, OP_XORI, OP_ORI,
    OP_ANDI, OP_SLLI, OP_SRLI, OP_SRAI,
    OP_ADDW, OP_SUBW, OP_SLLW, OP_SRLW, OP_SRAW,
    OP_ADDIW, OP_SLLIW, OP_SRLIW, OP_SRAIW,
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR,
    OP_BEQ, OP_BNE, OP_BLT, OP_BGE, OP_BLTU, OP_BGEU,
    OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI
  } exu_op_e;

endpackage

// ==== rtl/id_ex_if.sv ====
// Decode to execute link, four-phase req/ack with the operand payload.
interface id_ex_if import exu_pkg::*; ();

  logic      req;
  logic      ack;
  exu_op_e   op;
  xlen_t     op1;
  xlen_t     op2;
  xlen_t     op3;  // Branch or JAL target, pc+4 for JALR.
  reg_addr_t rd;
  logic      rd_we;
  xlen_t     pc;

  modport src (output req, op, op1, op2, op3, rd, rd_we, pc, input ack);
  modport dst (input req, op, op1, op2, op3, rd, rd_we, pc, output ack);

endinterface

// ==== rtl/id_stage.sv ====
// Decode stage: takes one instruction from the host, reads its operands and
// hands them to execute, stalling while a register it touches is pending.
module id_stage import exu_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  logic                i_inst_req,
  input  inst_t               i_inst,
  input  xlen_t               i_pc,
  output logic                o_inst_ack,
  output reg_addr_t           o_rs1_addr,
  output reg_addr_t           o_rs2_addr,
  input  xlen_t               i_rs1_data,
  input  xlen_t               i_rs2_data,
  output logic                o_mark_en,
  output reg_addr_t           o_mark_addr,
  input  logic [NUM_REGS-1:0] i_busy,
  id_ex_if.src                id_ex
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  reg_addr_t  rd;
  xlen_t      imm_i;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  exu_op_e    dec_op;
  xlen_t      dec_op1;
  xlen_t      dec_op2;
  xlen_t      dec_op3;
  logic       dec_we;
  logic       hazard;
  logic       accept;

  assign opcode     = i_inst[6:0];
  assign rd         = i_inst[11:7];
  assign funct3     = i_inst[14:12];
  assign funct7     = i_inst[31:25];
  assign o_rs1_addr = i_inst[19:15];
  assign o_rs2_addr = i_inst[24:20];

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21],
                  1'b0};

  always_comb begin
    dec_op  = OP_NOP;
    dec_op1 = i_rs1_data;
    dec_op2 = i_rs2_data;
    dec_op3 = '0;
    case (opcode)
      OPC_OP: begin
        case ({funct7, funct3})
          10'b0000000_000: dec_op = OP_ADD;
          10'b0100000_000: dec_op = OP_SUB;
          10'b0000000_001: dec_op = OP_SLL;
          10'b0000000_010: dec_op = OP_SLT;
          10'b0000000_011: dec_op = OP_SLTU;
          10'b0000000_100: dec_op = OP_XOR;
          10'b0000000_101: dec_op = OP_SRL;
          10'b0100000_101: dec_op = OP_SRA;
          10'b0000000_110: dec_op = OP_OR;
          10'b0000000_111: dec_op = OP_AND;
          default:         dec_op = OP_NOP;
        endcase
      end
      OPC_OP_IMM: begin
        dec_op2 = imm_i;
        case (funct3)
          3'b000: dec_op = OP_ADDI;
          3'b010: dec_op = OP_SLTI;
          3'b011: dec_op = OP_SLTIU;
          3'b100: dec_op = OP_XORI;
          3'b110: dec_op = OP_ORI;
          3'b111: dec_op = OP_ANDI;
          3'b001: begin
            if (funct7[6:1] == 6'b000000) begin
              dec_op = OP_SLLI;
            end
          end
          default: begin
            if (funct7[6:1] == 6'b000000) begin
              dec_op = OP_SRLI;
            end else if (funct7[6:1] == 6'b010000) begin
              dec_op = OP_SRAI;
            end
          end
        endcase
      end
      OPC_OP_32: begin
        case ({funct7, funct3})
          10'b0000000_000: dec_op = OP_ADDW;
          10'b0100000_000: dec_op = OP_SUBW;
          10'b0000000_001: dec_op = OP_SLLW;
          10'b0000000_101: dec_op = OP_SRLW;
          10'b0100000_101: dec_op = OP_SRAW;
          default:         dec_op = OP_NOP;
        endcase
      end
      OPC_OP_IMM_32: begin
        dec_op2 = imm_i;
        case ({funct7, funct3})
          10'b0000000_001: dec_op = OP_SLLIW;
          10'b0000000_101: dec_op = OP_SRLIW;
          10'b0100000_101: dec_op = OP_SRAIW;
          default: begin
            if (funct3 == 3'b000) begin
              dec_op = OP_ADDIW;
            end
          end
        endcase
      end
      OPC_LUI: begin
        dec_op  = OP_LUI;
        dec_op1 = imm_u;
        dec_op2 = '0;
      end
      OPC_AUIPC: begin
        dec_op  = OP_AUIPC;
        dec_op1 = i_pc;
        dec_op2 = imm_u;
      end
      OPC_JAL: begin
        dec_op  = OP_JAL;
        dec_op1 = i_pc;
        dec_op2 = 64'd4;
        dec_op3 = i_pc + imm_j;
      end
      OPC_JALR: begin
        if (funct3 == 3'b000) begin
          dec_op = OP_JALR;
        end
        dec_op2 = imm_i;
        dec_op3 = i_pc + 64'd4;
      end
      OPC_BRANCH: begin
        dec_op3 = i_pc + imm_b;
        case (funct3)
          3'b000:  dec_op = OP_BEQ;
          3'b001:  dec_op = OP_BNE;
          3'b100:  dec_op = OP_BLT;
          3'b101:  dec_op = OP_BGE;
          3'b110:  dec_op = OP_BLTU;
          3'b111:  dec_op = OP_BGEU;
          default: dec_op = OP_NOP;
        endcase
      end
      OPC_SYSTEM: begin
        if (funct3[2]) begin
          dec_op1 = {59'b0, i_inst[19:15]};  // Zero-extended uimm.
        end
        dec_op2 = {52'b0, i_inst[31:20]};  // CSR address.
        case (funct3)
          3'b001:  dec_op = OP_CSRRW;
          3'b010:  dec_op = OP_CSRRS;
          3'b011:  dec_op = OP_CSRRC;
          3'b101:  dec_op = OP_CSRRWI;
          3'b110:  dec_op = OP_CSRRSI;
          3'b111:  dec_op = OP_CSRRCI;
          default: dec_op = OP_NOP;
        endcase
      end
      default: dec_op = OP_NOP;
    endcase
  end

  assign dec_we = (dec_op != OP_NOP) && (opcode != OPC_BRANCH);

  // Conservative: the rs fields are checked even when the format has none.
  assign hazard = i_busy[o_rs1_addr] | i_busy[o_rs2_addr] | i_busy[rd];
  assign accept = i_inst_req && !o_inst_ack && !id_ex.req && !id_ex.ack && !hazard;

  assign o_mark_en   = accept && dec_we;
  assign o_mark_addr = rd;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_inst_ack <= 1'b0;
      id_ex.req  <= 1'b0;
    end else if (accept) begin
      o_inst_ack <= 1'b1;
      id_ex.req  <= 1'b1;
    end else begin
      if (o_inst_ack && !i_inst_req) begin
        o_inst_ack <= 1'b0;
      end
      if (id_ex.req && id_ex.ack) begin
        id_ex.req <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      id_ex.op    <= dec_op;
      id_ex.op1   <= dec_op1;
      id_ex.op2   <= dec_op2;
      id_ex.op3   <= dec_op3;
      id_ex.rd    <= rd;
      id_ex.rd_we <= dec_we;
      id_ex.pc    <= i_pc;
    end
  end

endmodule

// ==== rtl/reg_file.sv ====
// Integer register file with two asynchronous read ports and one write port.
// A pending bit per register tracks writes still in flight.
module reg_file import exu_pkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  reg_addr_t           i_rs1_addr,
  input  reg_addr_t           i_rs2_addr,
  output xlen_t               o_rs1_data,
  output xlen_t               o_rs2_data,
  input  logic                i_mark_en,
  input  reg_addr_t           i_mark_addr,
  input  logic                i_wr_en,
  input  reg_addr_t           i_wr_addr,
  input  xlen_t               i_wr_data,
  output logic [NUM_REGS-1:0] o_busy
);

  xlen_t regs [NUM_REGS];

  assign o_rs1_data = (i_rs1_addr == '0) ? '0 : regs[i_rs1_addr];
  assign o_rs2_data = (i_rs2_addr == '0) ? '0 : regs[i_rs2_addr];

  always_ff @(posedge clk) begin
    if (i_wr_en && (i_wr_addr != '0)) begin
      regs[i_wr_addr] <= i_wr_data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_busy <= '0;
    end else begin
      if (i_wr_en) begin
        o_busy[i_wr_addr] <= 1'b0;
      end
      if (i_mark_en && (i_mark_addr != '0)) begin
        o_busy[i_mark_addr] <= 1'b1;  // Later statement, so a mark beats a write.
      end
    end
  end

endmodule

// ==== rtl/wb_stage.sv ====
// Write-back stage: updates the register file and presents the commit.
// A new result is taken only after the host finishes the previous commit.
module wb_stage import exu_pkg::*; (
  input  logic      clk,
  input  logic      rst,
  ex_wb_if.dst      ex_wb,
  output logic      o_wr_en,
  output reg_addr_t o_wr_addr,
  output xlen_t     o_wr_data,
  output logic      o_cmt_req,
  output xlen_t     o_cmt_pc,
  output reg_addr_t o_cmt_rd,
  output logic      o_cmt_we,
  output xlen_t     o_cmt_wdata,
  output logic      o_cmt_jmp,
  output xlen_t     o_cmt_jmpaddr,
  output logic      o_cmt_skip,
  input  logic      i_cmt_ack
);

  logic accept;

  assign accept = ex_wb.req && !ex_wb.ack && !o_cmt_req && !i_cmt_ack;

  assign o_wr_en   = accept && ex_wb.rd_we && (ex_wb.rd != '0);
  assign o_wr_addr = ex_wb.rd;
  assign o_wr_data = ex_wb.wdata;

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_wb.ack <= 1'b0;
      o_cmt_req <= 1'b0;
    end else begin
      if (accept) begin
        ex_wb.ack <= 1'b1;
      end else if (ex_wb.ack && !ex_wb.req) begin
        ex_wb.ack <= 1'b0;
      end
      if (accept) begin
        o_cmt_req <= 1'b1;
      end else if (o_cmt_req && i_cmt_ack) begin
        o_cmt_req <= 1'b0;
      end
    end
  end

  // Commit payload stays put until the next accept.
  always_ff @(posedge clk) begin
    if (accept) begin
      o_cmt_pc      <= ex_wb.pc;
      o_cmt_rd      <= ex_wb.rd;
      o_cmt_we      <= ex_wb.rd_we && (ex_wb.rd != '0);
      o_cmt_wdata   <= ex_wb.wdata;
      o_cmt_jmp     <= ex_wb.jmp;
      o_cmt_jmpaddr <= ex_wb.jmpaddr;
      o_cmt_skip    <= ex_wb.skip;
    end
  end

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the pipeline testbench with Verilator and runs it once.
cd "$(dirname "$0")" &&
verilator --binary --timing -j 0 --top-module exu_core_tb -f build.f -o exu_core_sim &&
./obj_dir/exu_core_sim | tee /dev/stderr | grep -q "Regression passed" &&
echo "PASS" || { echo "FAIL"; exit 1; }
